// ==== board_pkg.sv ====
package board_pkg;

    // number of digit select lines on the board
    localparam int w_digit = 8;

    //----------------------------------------
    // seven-segment patterns
    //----------------------------------------

    //   --a--
    //  |     |
    //  f     b
    //  |     |
    //   --g--
    //  |     |
    //  e     c
    //  |     |
    //   --d--  h

    // segment a in the top bit, point h in bit 0
    typedef logic [7:0] seg_t;

    // nothing fires
    localparam seg_t seg_blank = 8'b0000_0000;
    // upper loop, moore only
    localparam seg_t seg_moore = 8'b1100_0110;
    // lower loop, mealy only
    localparam seg_t seg_mealy = 8'b0011_1010;
    // full eight without the point
    localparam seg_t seg_both  = 8'b1111_1110;

endpackage

// ==== fsm_pkg.sv ====
package fsm_pkg;

    //----------------------------------------
    // moore detector states
    //----------------------------------------

    typedef enum logic [1:0]
    {
        s_idle = 2'd0,  // no useful history
        s_zero = 2'd1,  // last accepted bit was 0
        s_hit  = 2'd2   // 0 then 1 just seen
    } moore_state_t;

    //----------------------------------------
    // mealy detector states
    //----------------------------------------

    // literals carry the machine name, the moore ones own s_idle and s_zero
    typedef enum logic
    {
        s_mealy_idle = 1'b0,
        s_mealy_zero = 1'b1   // last accepted bit was 0
    } mealy_state_t;

    // both detector outputs, mealy in the upper bit
    typedef struct packed
    {
        logic mealy;
        logic moore;
    } detect_t;

endpackage

// ==== strobe_gen.sv ====
`timescale 1ns/1ps

module strobe_gen
#(
    parameter int clk_mhz   = 50,
    parameter int strobe_hz = 3
)
(
    input  logic clk,
    input  logic rst_n,
    output logic strobe
);

    // clock cycles between strobes
    localparam int period = clk_mhz * 1000000 / strobe_hz;
    localparam int w_cnt  = period > 1 ? $clog2(period) : 1;

    logic [w_cnt - 1:0] cnt;

    //----------------------------------------
    // down-counter with reload at zero
    //----------------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            cnt <= w_cnt'(period - 1);
        else if (cnt == '0)
            cnt <= w_cnt'(period - 1);
        else
            cnt <= cnt - 1'b1;
    end

    // registered so it lines up with cnt == 0
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            strobe <= 1'b0;
        else
            strobe <= (cnt == w_cnt'(1));
    end

    // single-cycle pulse, never back to back
    a_strobe_single : assert property
    (
        @(posedge clk) disable iff (!rst_n)
        strobe |=> !strobe
    );

    // quiet once reset has been seen on an edge
    a_strobe_reset : assert property
    (
        @(posedge clk)
        !rst_n |=> !strobe
    );

endmodule

// ==== shift_reg.sv ====
`timescale 1ns/1ps

module shift_reg
#(
    parameter int depth = 8
)
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  logic               seq_in,
    output logic               seq_out,
    output logic [depth - 1:0] par_out
);

    //----------------------------------------
    // serial in at bit 0, shifts upward
    //----------------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            par_out <= '0;
        end
        else if (en)
        begin
            par_out <= { par_out[depth - 2:0], seq_in };
        end
    end

    // oldest bit leaves at the top
    assign seq_out = par_out[depth - 1];

    // contents only move on an enabled edge
    a_hold_without_en : assert property
    (
        @(posedge clk) disable iff (!rst_n)
        !en |=> $stable(par_out)
    );

endmodule

// ==== snail_moore_fsm.sv ====
`timescale 1ns/1ps

module snail_moore_fsm
(
    input  logic clk,
    input  logic rst_n,
    input  logic en,
    input  logic a,
    output logic y
);

    import fsm_pkg::*;

    moore_state_t state;
    moore_state_t next;

    //----------------------------------------
    // next state
    //----------------------------------------

    always_comb
    begin
        if (!a)
            next = s_zero;
        else if (state == s_zero)
            next = s_hit;
        else
            next = s_idle;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= s_idle;
        else if (en)
            state <= next;
    end

    // output depends on state only
    assign y = (state == s_hit);

    // no stray fourth encoding
    a_state_legal : assert property
    (
        @(posedge clk) disable iff (!rst_n)
        state inside {s_idle, s_zero, s_hit}
    );

    // a new hit needs an accepted 1 right after an accepted 0
    a_hit_after_zero : assert property
    (
        @(posedge clk) disable iff (!rst_n)
        y && !$past(y) |-> $past(en && a && state == s_zero)
    );

endmodule

// ==== snail_mealy_fsm.sv ====
`timescale 1ns/1ps

module snail_mealy_fsm
(
    input  logic clk,
    input  logic rst_n,
    input  logic en,
    input  logic a,
    output logic y
);

    import fsm_pkg::*;

    mealy_state_t state;
    mealy_state_t next;

    //----------------------------------------
    // state only remembers the last bit
    //----------------------------------------

    always_comb
    begin
        if (a)
            next = s_mealy_idle;
        else
            next = s_mealy_zero;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= s_mealy_idle;
        else if (en)
            state <= next;
    end

    // fires as soon as the 1 shows up after a 0
    assign y = (state == s_mealy_zero) && a;

    // an accepted 1 ends the match on the next cycle
    a_y_one_bit : assert property
    (
        @(posedge clk) disable iff (!rst_n)
        en && y |=> !y
    );

endmodule

// ==== lab_top.sv ====
`timescale 1ns/1ps

module lab_top
#(
    parameter int clk_mhz   = 50,
    parameter int strobe_hz = 3,
    parameter int w_key     = 4,
    parameter int w_led     = 8
)
(
    input  logic                             clk,
    input  logic                             rst_n,

    // keys and leds
    input  logic [w_key - 1:0]               key,
    output logic [w_led - 1:0]               led,

    // one lit digit of the display
    output board_pkg::seg_t                  abcdefgh,
    output logic [board_pkg::w_digit - 1:0]  digit
);

    import board_pkg::*;
    import fsm_pkg::*;

    logic    strobe;
    logic    key_any;
    logic    fsm_in;
    detect_t det;

    // any pressed key counts as a 1
    assign key_any = |key;

    //----------------------------------------
    // datapath
    //----------------------------------------

    strobe_gen
    #(
        .clk_mhz   (clk_mhz),
        .strobe_hz (strobe_hz)
    )
    i_strobe_gen
    (
        .clk    (clk),
        .rst_n  (rst_n),
        .strobe (strobe)
    );

    shift_reg
    #(
        .depth (w_led)
    )
    i_shift_reg
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (strobe),
        .seq_in  (key_any),
        .seq_out (fsm_in),
        .par_out (led)
    );

    snail_moore_fsm i_moore_fsm
    (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (strobe),
        .a     (fsm_in),
        .y     (det.moore)
    );

    snail_mealy_fsm i_mealy_fsm
    (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (strobe),
        .a     (fsm_in),
        .y     (det.mealy)
    );

    //----------------------------------------
    // display
    //----------------------------------------

    always_comb
    begin
        unique case ({ det.mealy, det.moore })
            2'b00:   abcdefgh = seg_blank;
            2'b01:   abcdefgh = seg_moore;
            2'b10:   abcdefgh = seg_mealy;
            default: abcdefgh = seg_both;
        endcase
    end

    // only the rightmost digit
    assign digit = w_digit'(1);

endmodule

// ==== tb_lab_top.sv ====
`timescale 1ns/1ps

module tb_lab_top;

    import board_pkg::*;
    import fsm_pkg::*;

    localparam int clk_mhz   = 1;
    localparam int strobe_hz = 100000;
    localparam int w_key     = 4;
    localparam int w_led     = 8;
    // cycles between strobes
    localparam int period    = clk_mhz * 1000000 / strobe_hz;

    logic                 clk;
    logic                 rst_n;
    logic [w_key - 1:0]   key;
    logic [w_led - 1:0]   led;
    seg_t                 abcdefgh;
    logic [w_digit - 1:0] digit;

    // cycle model
    int                   m_cnt;
    logic [w_led - 1:0]   m_led;
    moore_state_t         m_moore;
    mealy_state_t         m_mealy;
    logic                 m_en;
    logic [1:0]           m_det;
    seg_t                 m_seg;
    int                   cyc;
    int                   n_strobes;

    integer               seed;
    logic [w_key - 1:0]   cur_key;
    string                test_name;
    int                   test_errs;
    int                   n_tests;
    int                   n_failed;
    int                   total_errs;

    lab_top
    #(
        .clk_mhz   (clk_mhz),
        .strobe_hz (strobe_hz),
        .w_key     (w_key),
        .w_led     (w_led)
    )
    uut
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .key      (key),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //----------------------------------------
    // reporting helpers
    //----------------------------------------

    task automatic note_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
        $display("FAILED %s %s at cycle %0d: expected %0h, actual %0h",
                 test_name, what, cyc, exp, act);
        test_errs++;
    endtask

    task automatic note_problem(input string msg);
        $display("%s: %s", test_name, msg);
        test_errs++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        n_tests++;
        total_errs += test_errs;
        if (test_errs == 0)
            $display("test %s: pass", test_name);
        else
        begin
            n_failed++;
            $display("test %s: fail, %0d errors", test_name, test_errs);
        end
    endtask

    //----------------------------------------
    // model, one rising edge
    //----------------------------------------

    task automatic update_model(input logic [w_key - 1:0] k);
        logic a_bit;
        if (!rst_n)
        begin
            m_cnt     = period - 1;
            m_led     = '0;
            m_moore   = s_idle;
            m_mealy   = s_mealy_idle;
            m_en      = 1'b0;
            cyc       = 0;
            n_strobes = 0;
        end
        else
        begin
            cyc++;
            m_en = (m_cnt == 0);
            if (m_en)
            begin
                // detectors see the top bit before the shift
                a_bit   = m_led[w_led - 1];
                m_moore = !a_bit ? s_zero : (m_moore == s_zero ? s_hit : s_idle);
                m_mealy = a_bit ? s_mealy_idle : s_mealy_zero;
                m_led   = {m_led[w_led - 2:0], |k};
                m_cnt   = period - 1;
                n_strobes++;
            end
            else
                m_cnt--;
        end
        m_det = {(m_mealy == s_mealy_zero) && m_led[w_led - 1], m_moore == s_hit};
        case (m_det)
            2'b00:   m_seg = seg_blank;
            2'b01:   m_seg = seg_moore;
            2'b10:   m_seg = seg_mealy;
            default: m_seg = seg_both;
        endcase
    endtask

    // drive on the falling edge, check on the next falling edge
    task automatic run_cycle(input logic [w_key - 1:0] k);
        key = k;
        @(posedge clk);
        update_model(k);
        @(negedge clk);
        assert (led === m_led)
        else note_mismatch("led", 32'(m_led), 32'(led));
        assert (abcdefgh === m_seg)
        else note_mismatch("abcdefgh", 32'(m_seg), 32'(abcdefgh));
        assert (digit === w_digit'(1))
        else note_mismatch("digit", 32'(1), 32'(digit));
    endtask

    task automatic random_cycle();
        logic [31:0] r;
        r = $random(seed);
        // keys mostly held, now and then all released
        if (r[2:0] == 3'd0)
            cur_key = r[3] ? '0 : r[7:4];
        run_cycle(cur_key);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (16)
            random_cycle();
        rst_n = 1'b1;
    endtask

    // outputs stay quiet until the first strobe lands at cycle period
    task automatic check_idle_start();
        int first_change;
        int guard;
        first_change = -1;
        guard = 0;
        while (first_change < 0 && guard < 3 * period)
        begin
            run_cycle(4'b0100);
            guard++;
            if (led !== '0)
                first_change = cyc;
        end
        assert (first_change >= 0)
        else note_problem("led never changed after reset was released");
        assert (first_change < 0 || first_change == period)
        else note_mismatch("first strobe cycle", period, first_change);
    endtask

    //----------------------------------------
    // test sequence
    //----------------------------------------

    initial
    begin
        int                 start;
        int                 guard;
        int                 mealy_cyc;
        int                 pat_count [4];
        logic [w_led - 1:0] prev;

        seed       = 32'h953;
        rst_n      = 1'b0;
        key        = '0;
        cur_key    = '0;
        n_tests    = 0;
        n_failed   = 0;
        total_errs = 0;

        start_test("reset_idle");
        apply_reset();
        check_idle_start();
        end_test();

        start_test("strobe_shift");
        start = n_strobes;
        guard = 0;
        prev  = m_led;
        while (n_strobes < start + 20 && guard < 25 * period)
        begin
            random_cycle();
            guard++;
            if (m_en)
            begin
                assert (led === {prev[w_led - 2:0], |key})
                else note_mismatch("shifted led", 32'({prev[w_led - 2:0], |key}), 32'(led));
            end
            else
            begin
                assert (led === prev)
                else note_problem("led changed in a cycle without a strobe");
            end
            prev = m_led;
        end
        assert (n_strobes >= start + 20)
        else note_problem("timed out waiting for 20 strobes");
        end_test();

        // a single 1 travels up the register, so the detectors see 0 then 1
        start_test("mealy_detect");
        apply_reset();
        guard = 0;
        while (abcdefgh !== seg_mealy && guard < (w_led + 3) * period)
        begin
            run_cycle(n_strobes == 0 ? 4'b0001 : 4'b0000);
            guard++;
        end
        mealy_cyc = cyc;
        assert (abcdefgh === seg_mealy)
        else note_problem("mealy pattern never appeared on the display");
        assert (mealy_cyc == w_led * period)
        else note_mismatch("mealy fire cycle", w_led * period, mealy_cyc);
        end_test();

        start_test("moore_detect");
        guard = 0;
        while (abcdefgh !== seg_moore && guard < 3 * period)
        begin
            run_cycle(4'b0000);
            guard++;
        end
        assert (abcdefgh === seg_moore)
        else note_problem("moore pattern never appeared on the display");
        assert (cyc - mealy_cyc == period)
        else note_mismatch("moore lag behind mealy", period, cyc - mealy_cyc);
        end_test();

        start_test("random_run");
        pat_count = '{default: 0};
        start = n_strobes;
        guard = 0;
        while (n_strobes < start + 600 && guard < 650 * period)
        begin
            random_cycle();
            guard++;
            pat_count[m_det]++;
        end
        assert (n_strobes >= start + 600)
        else note_problem("timed out before 600 strobes");
        assert (pat_count[0] > 0 && pat_count[1] > 0 && pat_count[2] > 0)
        else note_problem("not every reachable display pattern was seen");
        end_test();

        start_test("mid_run_reset");
        repeat (7)
            random_cycle();
        apply_reset();
        check_idle_start();
        end_test();

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 n_tests, n_tests - n_failed, n_failed, total_errs);
        if (n_failed == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
board_pkg.sv
fsm_pkg.sv
strobe_gen.sv
shift_reg.sv
snail_moore_fsm.sv
snail_mealy_fsm.sv
lab_top.sv
tb_lab_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_lab_top -f src.f

out=$(./obj_dir/Vtb_lab_top)
echo "$out"

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
